//--- cgram_port.sv
// CPU port of the 256-color palette RAM, 15-bit colors in byte pairs
// Toggle selects low or high byte, each data access steps address and toggle
module cgram_port (
    input  logic clk,
    input  logic reset,
    input  ppu_bus_pkg::reg_op_t op,
    output logic [7:0] cg_byte
);
    import ppu_bus_pkg::*;
    import ppu_mem_pkg::*;

    cg_addr_t cg_addr;
    logic cg_tgl;
    cg_color_t ram_q;
    cg_color_t mem [2**$bits(cg_addr_t)];

    always_ff @(posedge clk) begin
        if (reset) begin
            {cg_addr, cg_tgl} <= '0;
        end else if (op.phase) begin
            case (op.op)
                CGADD: {cg_addr, cg_tgl} <= {op.wdata, 1'b0};
                CGDATA, RDCGRAM: {cg_addr, cg_tgl} <= {cg_addr, cg_tgl} + 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (op.phase && op.op == CGDATA) begin
            if (cg_tgl) begin
                mem[cg_addr][14:8] <= op.wdata[6:0];
            end else begin
                mem[cg_addr][7:0] <= op.wdata;
            end
        end
        ram_q <= mem[cg_addr];
    end

    // High byte reads with bit 7 clear
    assign cg_byte = cg_tgl ? {1'b0, ram_q[14:8]} : ram_q[7:0];

endmodule

//--- files.f
+incdir+.
ppu_bus_pkg.sv
ppu_mem_pkg.sv
ppu_bus_slave.sv
vram_port.sv
cgram_port.sv
ppu_multiplier.sv
hv_beam_latch.sv
ppu_regs_top.sv
tb_clock.sv
ppu_asserts.sv
tb_ppu_regs.sv

//--- hv_beam_latch.sv
// Free-running beam counter with software latch through SLHV
// Counter reads alternate between low byte and bit 8
// STAT78 read clears the latch flag and both read toggles
`include "ppu_config.svh"

module hv_beam_latch (
    input  logic clk,
    input  logic reset,
    input  ppu_bus_pkg::reg_op_t op,
    output logic [7:0] hv_byte
);
    import ppu_bus_pkg::*;

    logic [8:0] h_ctr;
    logic [8:0] v_ctr;
    logic [8:0] h_latch;
    logic [8:0] v_latch;
    logic latch_flag;
    logic h_tgl;
    logic v_tgl;

    // One dot per clock
    always_ff @(posedge clk) begin
        if (reset) begin
            h_ctr <= '0;
            v_ctr <= '0;
        end else if (h_ctr == 9'(`PPU_H_DOTS - 1)) begin
            h_ctr <= '0;
            v_ctr <= (v_ctr == 9'(`PPU_V_LINES - 1)) ? 9'd0 : v_ctr + 9'd1;
        end else begin
            h_ctr <= h_ctr + 9'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            h_latch <= '0;
            v_latch <= '0;
            latch_flag <= 1'b0;
            h_tgl <= 1'b0;
            v_tgl <= 1'b0;
        end else if (op.phase) begin
            case (op.op)
                SLHV: begin
                    h_latch <= h_ctr;
                    v_latch <= v_ctr;
                    latch_flag <= 1'b1;
                end
                OPHCT: h_tgl <= ~h_tgl;
                OPVCT: v_tgl <= ~v_tgl;
                STAT78: begin
                    latch_flag <= 1'b0;
                    h_tgl <= 1'b0;
                    v_tgl <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        case (op.op)
            OPHCT: hv_byte = h_tgl ? {7'h00, h_latch[8]} : h_latch[7:0];
            OPVCT: hv_byte = v_tgl ? {7'h00, v_latch[8]} : v_latch[7:0];
            STAT78: hv_byte = {1'b0, latch_flag, 2'b00, 4'(`PPU_VERSION)};
            default: hv_byte = 8'h00;
        endcase
    end

endmodule

//--- ppu_asserts.sv
// Wishbone handshake checks on the bus front end
// Assumes one transfer at a time with a single-cycle ack
module ppu_asserts (
    input logic clk,
    input logic reset,
    input logic cyc,
    input logic stb,
    input logic ack
);

    ack_needs_request: assert property (@(posedge clk) disable iff (reset)
        ack |-> (cyc && stb))
        else $error("ack raised without cyc and stb");

    ack_single_cycle: assert property (@(posedge clk) disable iff (reset)
        ack |=> !ack)
        else $error("ack held high for two cycles");

    ack_low_after_reset: assert property (@(posedge clk) reset |=> !ack)
        else $error("ack high in the cycle after reset");

endmodule

bind ppu_bus_slave ppu_asserts i_asserts (
    .clk(clk),
    .reset(reset),
    .cyc(cyc),
    .stb(stb),
    .ack(ack)
);

//--- ppu_bus_pkg.sv
// CPU-side types shared by the Wishbone front end and the register units
// An operation stays set for two cycles, with phase 0 then phase 1
package ppu_bus_pkg;

    typedef enum logic [4:0] {
        NONE,
        // Writes
        VMAIN,
        VMADDL,
        VMADDH,
        VMDATAL,
        VMDATAH,
        M7A,
        M7B,
        CGADD,
        CGDATA,
        // Reads
        MPYL,
        MPYM,
        MPYH,
        SLHV,
        RDVRAML,
        RDVRAMH,
        RDCGRAM,
        OPHCT,
        OPVCT,
        STAT78
    } reg_op_e;

    typedef struct packed {
        reg_op_e op;
        logic phase;        // 1 in the ack cycle, side effects commit at its end
        logic [7:0] wdata;
    } reg_op_t;

    typedef struct packed {
        logic [7:0] vram_lo;
        logic [7:0] vram_hi;
        logic [7:0] cg_byte;
        logic [2:0][7:0] mpy;
        logic [7:0] hv_byte;
    } readback_t;

endpackage

//--- ppu_bus_slave.sv
// Wishbone classic front end, ack one cycle after the request
// Master must hold adr, we and dat_w until ack
// Unmapped offsets and write-only registers read as zero
`include "ppu_config.svh"

module ppu_bus_slave (
    input  logic clk,
    input  logic reset,
    input  logic cyc,
    input  logic stb,
    input  logic we,
    input  logic [`PPU_ADR_W-1:0] adr,
    input  logic [7:0] dat_w,
    input  ppu_bus_pkg::readback_t rb,
    output logic ack,
    output logic [7:0] dat_r,
    output ppu_bus_pkg::reg_op_t op
);
    import ppu_bus_pkg::*;

    logic req;
    reg_op_e op_dec;

    assign req = cyc & stb;

    // Reads and writes share offsets, so decode with we
    always_comb begin
        case ({we, adr})
            {1'b1, 6'h15}: op_dec = VMAIN;
            {1'b1, 6'h16}: op_dec = VMADDL;
            {1'b1, 6'h17}: op_dec = VMADDH;
            {1'b1, 6'h18}: op_dec = VMDATAL;
            {1'b1, 6'h19}: op_dec = VMDATAH;
            {1'b1, 6'h1b}: op_dec = M7A;
            {1'b1, 6'h1c}: op_dec = M7B;
            {1'b1, 6'h21}: op_dec = CGADD;
            {1'b1, 6'h22}: op_dec = CGDATA;
            {1'b0, 6'h34}: op_dec = MPYL;
            {1'b0, 6'h35}: op_dec = MPYM;
            {1'b0, 6'h36}: op_dec = MPYH;
            {1'b0, 6'h37}: op_dec = SLHV;
            {1'b0, 6'h39}: op_dec = RDVRAML;
            {1'b0, 6'h3a}: op_dec = RDVRAMH;
            {1'b0, 6'h3b}: op_dec = RDCGRAM;
            {1'b0, 6'h3c}: op_dec = OPHCT;
            {1'b0, 6'h3d}: op_dec = OPVCT;
            {1'b0, 6'h3f}: op_dec = STAT78;
            default: op_dec = NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= req & ~ack;
        end
    end

    always_comb begin
        op.op = req ? op_dec : NONE;
        op.phase = ack;
        op.wdata = dat_w;
    end

    // Read data
    always_comb begin
        case (op.op)
            RDVRAML: dat_r = rb.vram_lo;
            RDVRAMH: dat_r = rb.vram_hi;
            RDCGRAM: dat_r = rb.cg_byte;
            MPYL: dat_r = rb.mpy[0];
            MPYM: dat_r = rb.mpy[1];
            MPYH: dat_r = rb.mpy[2];
            OPHCT, OPVCT, STAT78: dat_r = rb.hv_byte;
            default: dat_r = 8'h00;
        endcase
    end

endmodule

//--- ppu_config.svh
// Sizes and limits of the register block
// Register offsets are the low 6 bits of the original map
// The beam counter limits describe one non-interlaced NTSC frame
`ifndef PPU_CONFIG_SVH
`define PPU_CONFIG_SVH

`define PPU_VRAM_AW 15
`define PPU_CG_AW 8

`define PPU_H_DOTS 341
`define PPU_V_LINES 262

`define PPU_VERSION 2
`define PPU_ADR_W 6

`endif

//--- ppu_mem_pkg.sv
// Memory-side types of the VRAM and palette ports and the multiplier
// Widths come from the shared config header
`include "ppu_config.svh"

package ppu_mem_pkg;

    typedef logic [`PPU_VRAM_AW-1:0] vram_addr_t;
    typedef logic [15:0] vram_word_t;

    typedef struct packed {
        logic inc_on_high;
        logic [1:0] remap;
        logic [1:0] step;
    } vram_ctrl_t;

    typedef logic [`PPU_CG_AW-1:0] cg_addr_t;
    typedef logic [14:0] cg_color_t;

    // Product seen as a number or as the MPYL/MPYM/MPYH bytes
    typedef union packed {
        logic signed [23:0] value;
        logic [2:0][7:0] bytes;
    } mpy_result_u;

endpackage

//--- ppu_multiplier.sv
// Signed 16 x 8 multiplier on the mode-7 matrix A and B registers
// Each operand is loaded by two writes, low byte first
module ppu_multiplier (
    input  logic clk,
    input  logic reset,
    input  ppu_bus_pkg::reg_op_t op,
    output logic [2:0][7:0] mpy
);
    import ppu_bus_pkg::*;
    import ppu_mem_pkg::*;

    logic [7:0] old_byte;
    logic [15:0] m7_a;
    logic [15:0] m7_b;
    mpy_result_u product;

    always_ff @(posedge clk) begin
        if (reset) begin
            old_byte <= '0;
            m7_a <= '0;
            m7_b <= '0;
        end else if (op.phase && (op.op == M7A || op.op == M7B)) begin
            if (op.op == M7A) begin
                m7_a <= {op.wdata, old_byte};
            end else begin
                m7_b <= {op.wdata, old_byte};
            end
            old_byte <= op.wdata;
        end
    end

    // Only the high byte of B takes part
    assign product.value = $signed(m7_a) * $signed(m7_b[15:8]);
    assign mpy = product.bytes;

endmodule

//--- ppu_regs_top.sv
// CPU register block of the video processor, Wishbone classic slave
// One fixed wait cycle per access, no errors or retries
// The CPU always owns both RAMs
`include "ppu_config.svh"

module ppu_regs_top (
    input  logic clk,
    input  logic reset,
    input  logic cyc,
    input  logic stb,
    input  logic we,
    input  logic [`PPU_ADR_W-1:0] adr,
    input  logic [7:0] dat_w,
    output logic [7:0] dat_r,
    output logic ack
);
    import ppu_bus_pkg::*;

    reg_op_t op;
    readback_t rb;

    ppu_bus_slave i_bus_slave (
        .clk(clk),
        .reset(reset),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .adr(adr),
        .dat_w(dat_w),
        .rb(rb),
        .ack(ack),
        .dat_r(dat_r),
        .op(op)
    );

    vram_port i_vram_port (
        .clk(clk),
        .reset(reset),
        .op(op),
        .vram_lo(rb.vram_lo),
        .vram_hi(rb.vram_hi)
    );

    cgram_port i_cgram_port (
        .clk(clk),
        .reset(reset),
        .op(op),
        .cg_byte(rb.cg_byte)
    );

    ppu_multiplier i_multiplier (
        .clk(clk),
        .reset(reset),
        .op(op),
        .mpy(rb.mpy)
    );

    hv_beam_latch i_hv_beam_latch (
        .clk(clk),
        .reset(reset),
        .op(op),
        .hv_byte(rb.hv_byte)
    );

endmodule

//--- run.sh
#!/bin/sh
# Build and run the register block testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module tb_ppu_regs -f files.f
status=0
./obj_dir/Vtb_ppu_regs > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "Finished with errors" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- tb_clock.sv
// Free-running testbench clock, period of 4 time units
// Starts low at time 0
module tb_clock (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always begin
        #2 clk = ~clk;
    end

endmodule

//--- tb_ppu_regs.sv
// Register block testbench with random stimulus against a reference model
// Transfers run one at a time with one idle cycle between them
// VRAM words are only read back after both bytes were written
`include "ppu_config.svh"

module tb_ppu_regs;
    import ppu_mem_pkg::*;

    // Transfers in the reset, VRAM, palette, multiplier, beam and latch flag tests
    localparam int N_XFERS = 22 + 32 * 21 + 66 + 16 * 7 + 8 * 6 + 5;
    localparam int CYCLE_LIMIT = 20 * N_XFERS + 200;

    logic clk;
    logic reset;
    logic cyc;
    logic stb;
    logic we;
    logic [`PPU_ADR_W-1:0] adr;
    logic [7:0] dat_w;
    logic [7:0] dat_r;
    logic ack;

    int errors;
    int checks;
    int err_mark;
    int chk_mark;
    int n_tests;
    int cycles;
    int ticks;
    int ack_ticks;

    // Reference model state
    logic [15:0] vmem [2**`PPU_VRAM_AW];
    logic [`PPU_VRAM_AW-1:0] vaddr;
    logic [15:0] vpre;
    logic v_inc_hi;
    logic [1:0] v_remap;
    logic [1:0] v_step;
    logic [14:0] cmem [2**`PPU_CG_AW];
    logic [`PPU_CG_AW-1:0] c_addr;
    logic c_tgl;
    logic [7:0] m_old;
    logic [15:0] m_a;
    logic [15:0] m_b;
    logic [8:0] h_lat;
    logic [8:0] v_lat;
    logic hv_flag;
    logic h_tgl;
    logic v_tgl;

    tb_clock i_clock (
        .clk(clk)
    );

    ppu_regs_top i_dut (
        .clk(clk),
        .reset(reset),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .adr(adr),
        .dat_w(dat_w),
        .dat_r(dat_r),
        .ack(ack)
    );

    // Dots since reset release give the beam position
    always @(posedge clk) begin
        if (reset) begin
            ticks <= 0;
        end else begin
            ticks <= ticks + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------

    // Remap rotates the low 8, 9 or 10 address bits left by 3
    function automatic logic [14:0] vram_eff(input logic [14:0] a, input logic [1:0] mode);
        int w;
        int mask;
        int field;
        if (mode == 2'd0) begin
            return a;
        end
        w = 7 + int'(mode);
        mask = (1 << w) - 1;
        field = int'(a) & mask;
        field = ((field << 3) | (field >> (w - 3))) & mask;
        return 15'((int'(a) & ~mask) | field);
    endfunction

    function automatic logic [14:0] vram_step(input logic [1:0] s);
        if (s[1]) begin
            return 15'd128;
        end else if (s[0]) begin
            return 15'd32;
        end
        return 15'd1;
    endfunction

    function automatic mpy_result_u mpy_expect(input logic [15:0] a, input logic [15:0] b);
        shortint sa;
        byte sb;
        int p;
        mpy_result_u r;
        sa = a;
        sb = b[15:8];
        p = sa * sb;
        r.value = p[23:0];
        return r;
    endfunction

    // Applies one committed transfer and gives the byte the bus returns
    task automatic model_op(input logic w, input logic [5:0] a, input logic [7:0] d,
                            output logic [7:0] exp);
        logic [14:0] ea;
        logic inc;
        mpy_result_u prod;
        exp = 8'h00;
        inc = 1'b0;
        ea = vram_eff(vaddr, v_remap);
        if (w) begin
            case (a)
                6'h15: {v_inc_hi, v_remap, v_step} = {d[7], d[3:0]};
                6'h16: begin
                    vaddr[7:0] = d;
                    vpre = vmem[vram_eff(vaddr, v_remap)];
                end
                6'h17: begin
                    vaddr[14:8] = d[6:0];
                    vpre = vmem[vram_eff(vaddr, v_remap)];
                end
                6'h18: begin
                    vmem[ea][7:0] = d;
                    inc = !v_inc_hi;
                end
                6'h19: begin
                    vmem[ea][15:8] = d;
                    inc = v_inc_hi;
                end
                6'h1b: begin
                    m_a = {d, m_old};
                    m_old = d;
                end
                6'h1c: begin
                    m_b = {d, m_old};
                    m_old = d;
                end
                6'h21: begin
                    c_addr = d;
                    c_tgl = 1'b0;
                end
                6'h22: begin
                    if (c_tgl) begin
                        cmem[c_addr][14:8] = d[6:0];
                    end else begin
                        cmem[c_addr][7:0] = d;
                    end
                    {c_addr, c_tgl} = {c_addr, c_tgl} + 9'd1;
                end
                default: ;
            endcase
        end else begin
            case (a)
                6'h34, 6'h35, 6'h36: begin
                    prod = mpy_expect(m_a, m_b);
                    exp = prod.bytes[a - 6'h34];
                end
                6'h37: begin
                    h_lat = 9'(ack_ticks % `PPU_H_DOTS);
                    v_lat = 9'((ack_ticks / `PPU_H_DOTS) % `PPU_V_LINES);
                    hv_flag = 1'b1;
                end
                6'h39: begin
                    exp = vpre[7:0];
                    inc = !v_inc_hi;
                end
                6'h3a: begin
                    exp = vpre[15:8];
                    inc = v_inc_hi;
                end
                6'h3b: begin
                    exp = c_tgl ? {1'b0, cmem[c_addr][14:8]} : cmem[c_addr][7:0];
                    {c_addr, c_tgl} = {c_addr, c_tgl} + 9'd1;
                end
                6'h3c: begin
                    exp = h_tgl ? {7'h00, h_lat[8]} : h_lat[7:0];
                    h_tgl = !h_tgl;
                end
                6'h3d: begin
                    exp = v_tgl ? {7'h00, v_lat[8]} : v_lat[7:0];
                    v_tgl = !v_tgl;
                end
                6'h3f: begin
                    // Flag in bit 6, version in the low nibble
                    exp = (hv_flag ? 8'h40 : 8'h00) | 8'(`PPU_VERSION);
                    hv_flag = 1'b0;
                    h_tgl = 1'b0;
                    v_tgl = 1'b0;
                end
                default: ;
            endcase
            // Stepping read reloads the prefetch from the old address
            if (inc) begin
                vpre = vmem[ea];
            end
        end
        if (inc) begin
            vaddr = vaddr + vram_step(v_step);
        end
    endtask

    // ----------------------------------------------------------------------
    // Bus, checks and report
    // ----------------------------------------------------------------------

    task automatic bus(input logic w, input logic [5:0] a, input logic [7:0] d,
                       output logic [7:0] q);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we <= w;
        adr <= a;
        dat_w <= d;
        @(negedge clk);
        while (ack !== 1'b1) begin
            @(negedge clk);
        end
        q = dat_r;
        ack_ticks = ticks;
        // Commit edge
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at time %0t: %s is %02h, expected %02h", $time, name, got, exp);
        end
    endtask

    task automatic check_product(input string name, input mpy_result_u got,
                                 input mpy_result_u exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at time %0t: %s is %06h, expected %06h",
                     $time, name, got.bytes, exp.bytes);
        end
    endtask

    task automatic access(input logic w, input logic [5:0] a, input logic [7:0] d,
                          input string name);
        logic [7:0] got;
        logic [7:0] exp;
        bus(w, a, d, got);
        model_op(w, a, d, exp);
        check_byte({"dat_r on ", name}, got, exp);
    endtask

    task automatic begin_test();
        err_mark = errors;
        chk_mark = checks;
    endtask

    task automatic end_test(input string name);
        n_tests++;
        $display("test %s: %0d checks, %0d errors", name, checks - chk_mark, errors - err_mark);
    endtask

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------

    task automatic test_unmapped();
        logic [5:0] write_only [9] = '{6'h15, 6'h16, 6'h17, 6'h18, 6'h19,
                                       6'h1b, 6'h1c, 6'h21, 6'h22};
        logic [5:0] unmapped [6] = '{6'h00, 6'h10, 6'h2f, 6'h34, 6'h39, 6'h3f};
        begin_test();
        foreach (write_only[i]) begin
            access(1'b0, write_only[i], 8'h00, "write-only read");
        end
        foreach (unmapped[i]) begin
            access(1'b1, unmapped[i], 8'($urandom), "unmapped write");
        end
        access(1'b0, 6'h34, 8'h00, "MPYL");
        access(1'b0, 6'h35, 8'h00, "MPYM");
        access(1'b0, 6'h36, 8'h00, "MPYH");
        access(1'b0, 6'h3a, 8'h00, "RDVRAMH");
        access(1'b0, 6'h3c, 8'h00, "OPHCT");
        access(1'b0, 6'h3d, 8'h00, "OPVCT");
        access(1'b0, 6'h3f, 8'h00, "STAT78");
        end_test("reset_and_unmapped");
    endtask

    task automatic test_vram();
        logic [14:0] base;
        begin_test();
        for (int c = 0; c < 32; c++) begin
            base = 15'($urandom);
            // Bits 6..4 of VMAIN are unused
            access(1'b1, 6'h15, {c[4], 3'($urandom), c[3:0]}, "VMAIN");
            access(1'b1, 6'h16, base[7:0], "VMADDL");
            access(1'b1, 6'h17, {1'($urandom), base[14:8]}, "VMADDH");
            // Byte that does not step the address goes first so words fill whole
            repeat (4) begin
                if (c[4]) begin
                    access(1'b1, 6'h18, 8'($urandom), "VMDATAL");
                    access(1'b1, 6'h19, 8'($urandom), "VMDATAH");
                end else begin
                    access(1'b1, 6'h19, 8'($urandom), "VMDATAH");
                    access(1'b1, 6'h18, 8'($urandom), "VMDATAL");
                end
            end
            access(1'b1, 6'h16, base[7:0], "VMADDL");
            access(1'b1, 6'h17, {1'b0, base[14:8]}, "VMADDH");
            repeat (4) begin
                if (c[4]) begin
                    access(1'b0, 6'h39, 8'h00, "RDVRAML");
                    access(1'b0, 6'h3a, 8'h00, "RDVRAMH");
                end else begin
                    access(1'b0, 6'h3a, 8'h00, "RDVRAMH");
                    access(1'b0, 6'h39, 8'h00, "RDVRAML");
                end
            end
        end
        end_test("vram_access");
    endtask

    task automatic test_palette();
        logic [7:0] base;
        logic [14:0] color;
        begin_test();
        base = 8'($urandom);
        access(1'b1, 6'h21, base, "CGADD");
        repeat (16) begin
            color = 15'($urandom);
            access(1'b1, 6'h22, color[7:0], "CGDATA");
            access(1'b1, 6'h22, {1'($urandom), color[14:8]}, "CGDATA");
        end
        access(1'b1, 6'h21, base, "CGADD");
        repeat (32) begin
            access(1'b0, 6'h3b, 8'h00, "RDCGRAM");
        end
        end_test("palette");
    endtask

    task automatic test_multiplier();
        logic [7:0] q;
        mpy_result_u got;
        mpy_result_u exp;
        begin_test();
        repeat (16) begin
            access(1'b1, 6'h1b, 8'($urandom), "M7A");
            access(1'b1, 6'h1b, 8'($urandom), "M7A");
            access(1'b1, 6'h1c, 8'($urandom), "M7B");
            access(1'b1, 6'h1c, 8'($urandom), "M7B");
            for (int k = 0; k < 3; k++) begin
                bus(1'b0, 6'(6'h34 + k), 8'h00, q);
                got.bytes[k] = q;
                model_op(1'b0, 6'(6'h34 + k), 8'h00, q);
                exp.bytes[k] = q;
            end
            check_product("MPYH:MPYM:MPYL", got, exp);
        end
        end_test("multiplier");
    endtask

    task automatic test_beam();
        begin_test();
        repeat (8) begin
            repeat (int'($urandom % 16)) @(posedge clk);
            access(1'b0, 6'h3f, 8'h00, "STAT78");
            access(1'b0, 6'h37, 8'h00, "SLHV");
            access(1'b0, 6'h3c, 8'h00, "OPHCT");
            access(1'b0, 6'h3c, 8'h00, "OPHCT");
            access(1'b0, 6'h3d, 8'h00, "OPVCT");
            access(1'b0, 6'h3d, 8'h00, "OPVCT");
        end
        end_test("beam_latch");
    endtask

    task automatic test_latch_flag();
        begin_test();
        access(1'b0, 6'h37, 8'h00, "SLHV");
        // Leaves the OPHCT toggle on the high byte
        access(1'b0, 6'h3c, 8'h00, "OPHCT");
        access(1'b0, 6'h3f, 8'h00, "STAT78");
        access(1'b0, 6'h3f, 8'h00, "STAT78");
        access(1'b0, 6'h3c, 8'h00, "OPHCT");
        end_test("latch_flag");
    endtask

    initial begin
        void'($urandom(32'he479));
        reset = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = 8'h00;
        vaddr = '0;
        vpre = 16'h0000;
        {v_inc_hi, v_remap, v_step} = 5'b00000;
        c_addr = '0;
        c_tgl = 1'b0;
        m_old = 8'h00;
        m_a = 16'h0000;
        m_b = 16'h0000;
        h_lat = 9'd0;
        v_lat = 9'd0;
        {hv_flag, h_tgl, v_tgl} = 3'b000;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        test_unmapped();
        test_vram();
        test_palette();
        test_multiplier();
        test_beam();
        test_latch_flag();

        $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- vram_port.sv
// CPU port of the 32K-word VRAM with address remap and auto increment
// Reads return the prefetched word, so data lags the address by one access
// RAM contents are undefined until written
module vram_port (
    input  logic clk,
    input  logic reset,
    input  ppu_bus_pkg::reg_op_t op,
    output logic [7:0] vram_lo,
    output logic [7:0] vram_hi
);
    import ppu_bus_pkg::*;
    import ppu_mem_pkg::*;

    vram_ctrl_t ctrl;
    vram_addr_t addr;
    vram_addr_t addr_sel;
    vram_addr_t addr_eff;
    vram_addr_t step;
    vram_word_t ram_q;
    vram_word_t prefetch;
    vram_word_t mem [2**$bits(vram_addr_t)];
    logic commit;
    logic inc_hit;

    assign commit = op.phase;

    // ------------------------------------------------------------------
    // Address path
    // ------------------------------------------------------------------

    // Address writes already point the RAM at the new address
    always_comb begin
        case (op.op)
            VMADDL: addr_sel = {addr[14:8], op.wdata};
            VMADDH: addr_sel = {op.wdata[6:0], addr[7:0]};
            default: addr_sel = addr;
        endcase
    end

    // Rotate low 8, 9 or 10 bits left by 3
    always_comb begin
        case (ctrl.remap)
            2'd1: addr_eff = {addr_sel[14:8], addr_sel[4:0], addr_sel[7:5]};
            2'd2: addr_eff = {addr_sel[14:9], addr_sel[5:0], addr_sel[8:6]};
            2'd3: addr_eff = {addr_sel[14:10], addr_sel[6:0], addr_sel[9:7]};
            default: addr_eff = addr_sel;
        endcase
    end

    always_comb begin
        if (ctrl.step[1]) begin
            step = vram_addr_t'(128);
        end else if (ctrl.step[0]) begin
            step = vram_addr_t'(32);
        end else begin
            step = vram_addr_t'(1);
        end
    end

    assign inc_hit = commit & (ctrl.inc_on_high
        ? (op.op == VMDATAH || op.op == RDVRAMH)
        : (op.op == VMDATAL || op.op == RDVRAML));

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl <= '0;
            addr <= '0;
        end else if (commit) begin
            if (op.op == VMAIN) begin
                ctrl <= vram_ctrl_t'({op.wdata[7], op.wdata[3:0]});
            end
            if (op.op == VMADDL || op.op == VMADDH) begin
                addr <= addr_sel;
            end else if (inc_hit) begin
                addr <= addr + step;
            end
        end
    end

    // ------------------------------------------------------------------
    // RAM and prefetch
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (commit && op.op == VMDATAL) begin
            mem[addr_eff][7:0] <= op.wdata;
        end
        if (commit && op.op == VMDATAH) begin
            mem[addr_eff][15:8] <= op.wdata;
        end
        ram_q <= mem[addr_eff];
    end

    // Word read in the request cycle, taken before the increment
    always_ff @(posedge clk) begin
        if (reset) begin
            prefetch <= '0;
        end else if (inc_hit && (op.op == RDVRAML || op.op == RDVRAMH)) begin
            prefetch <= ram_q;
        end else if (commit && (op.op == VMADDL || op.op == VMADDH)) begin
            prefetch <= ram_q;
        end
    end

    assign vram_lo = prefetch[7:0];
    assign vram_hi = prefetch[15:8];

endmodule
